//--- filelist.f
+incdir+.
id_pkg.sv
fwd_if.sv
regfile.sv
inst_decoder.sv
operand_fetch.sv
branch_issue.sv
id_stage.sv
tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_id_stage
FILELIST  ?= filelist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(shell grep -v '^+' $(FILELIST)) id_cfg.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

//--- tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module tb_id_stage
    import id_pkg::*;
;

    typedef enum {
        k_add_w, k_sub_w, k_slt, k_sltu, k_and, k_or, k_nor, k_xor, k_sll_w, k_srl_w, k_sra_w,
        k_addi_w, k_slti, k_sltui, k_andi, k_ori, k_xori, k_slli_w, k_srli_w, k_srai_w,
        k_lu12i_w, k_pcaddu12i, k_ld_w, k_st_w,
        k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu, k_b, k_bl, k_jirl
    } kind_e;

    typedef struct {
        kind_e       kind;
        logic [4:0]  rd, rj, rk;
        logic [31:0] imm, pc;
        logic [4:0]  es_dest, ms_dest, ws_dest;
        logic [31:0] es_res, ms_res, ws_res;
        int          stall, gap;
    } entry_t;

    typedef struct {
        alu_op_e     alu;
        logic        src1_pc, src2_imm, gr_we, mem_we, from_mem, use_rj, use_rkd, taken;
        logic [4:0]  dest;
        logic [31:0] imm, rj_val, rkd_val, target, pc;
    } exp_t;

    logic clk = 1'b0;
    logic reset;
    logic in_valid, in_ready, out_valid, out_ready;
    logic [31:0] in_inst, in_pc;
    alu_op_e out_alu_op;
    logic out_src1_is_pc, out_src2_is_imm, out_gr_we, out_mem_we, out_res_from_mem;
    logic [4:0] out_dest;
    logic [31:0] out_imm, out_rj_value, out_rkd_value, out_pc;
    logic br_taken;
    logic [31:0] br_target;
    logic wb_we;
    logic [4:0] wb_addr, es_dest, ms_dest, ws_dest;
    logic [31:0] wb_data, es_result, ms_result, ws_result;
    logic es_load;

    logic [31:0] shadow [32];
    entry_t table_q [$];
    int errors = 0;
    int cycles = 0;
    int limit = 100000;

    always #2 clk = ~clk;

    id_stage i_dut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("run stopped after %0d cycles waiting on the DUT handshake", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("ERR %0t: %s mismatch", $time, what);
        end
    endtask

    function automatic logic [31:0] encode(entry_t e);
        logic [4:0] o5;
        logic [3:0] o4;
        case (e.kind)
            k_add_w, k_sub_w, k_slt, k_sltu, k_and, k_or, k_nor, k_xor,
            k_sll_w, k_srl_w, k_sra_w: begin
                case (e.kind)
                    k_add_w: o5 = 5'h00;
                    k_sub_w: o5 = 5'h02;
                    k_slt:   o5 = 5'h04;
                    k_sltu:  o5 = 5'h05;
                    k_nor:   o5 = 5'h08;
                    k_and:   o5 = 5'h09;
                    k_or:    o5 = 5'h0a;
                    k_xor:   o5 = 5'h0b;
                    k_sll_w: o5 = 5'h0e;
                    k_srl_w: o5 = 5'h0f;
                    default: o5 = 5'h10;
                endcase
                return {6'h00, 4'h0, 2'h1, o5, e.rk, e.rj, e.rd};
            end
            k_slli_w: return {6'h00, 4'h1, 2'h0, 5'h01, e.imm[4:0], e.rj, e.rd};
            k_srli_w: return {6'h00, 4'h1, 2'h0, 5'h09, e.imm[4:0], e.rj, e.rd};
            k_srai_w: return {6'h00, 4'h1, 2'h0, 5'h11, e.imm[4:0], e.rj, e.rd};
            k_slti, k_sltui, k_addi_w, k_andi, k_ori, k_xori: begin
                case (e.kind)
                    k_slti:   o4 = 4'h8;
                    k_sltui:  o4 = 4'h9;
                    k_addi_w: o4 = 4'ha;
                    k_andi:   o4 = 4'hd;
                    k_ori:    o4 = 4'he;
                    default:  o4 = 4'hf;
                endcase
                return {6'h00, o4, e.imm[11:0], e.rj, e.rd};
            end
            k_lu12i_w:   return {7'h0a, e.imm[19:0], e.rd};
            k_pcaddu12i: return {7'h0e, e.imm[19:0], e.rd};
            k_ld_w:      return {6'h0a, 4'h2, e.imm[11:0], e.rj, e.rd};
            k_st_w:      return {6'h0a, 4'h6, e.imm[11:0], e.rj, e.rd};
            k_jirl:      return {6'h13, e.imm[15:0], e.rj, e.rd};
            k_b:         return {6'h14, e.imm[15:0], e.imm[25:16]};
            k_bl:        return {6'h15, e.imm[15:0], e.imm[25:16]};
            k_beq:       return {6'h16, e.imm[15:0], e.rj, e.rd};
            k_bne:       return {6'h17, e.imm[15:0], e.rj, e.rd};
            k_blt:       return {6'h18, e.imm[15:0], e.rj, e.rd};
            k_bge:       return {6'h19, e.imm[15:0], e.rj, e.rd};
            k_bltu:      return {6'h1a, e.imm[15:0], e.rj, e.rd};
            default:     return {6'h1b, e.imm[15:0], e.rj, e.rd};
        endcase
    endfunction

    // youngest stage first, r0 is always zero
    function automatic logic [31:0] source_value(entry_t e, logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (e.es_dest == a) return e.es_res;
        if (e.ms_dest == a) return e.ms_res;
        if (e.ws_dest == a) return e.ws_res;
        return shadow[a];
    endfunction

    function automatic exp_t model(entry_t e);
        exp_t x;
        logic [31:0] s12, off16, off26;
        s12 = {{20{e.imm[11]}}, e.imm[11:0]};
        off16 = {{14{e.imm[15]}}, e.imm[15:0], 2'b00};
        off26 = {{4{e.imm[25]}}, e.imm[25:0], 2'b00};
        x = '{alu: add, dest: e.rd, imm: s12, default: '0};
        case (e.kind)
            k_add_w, k_sub_w, k_slt, k_sltu, k_and, k_or, k_nor, k_xor,
            k_sll_w, k_srl_w, k_sra_w: begin
                x.gr_we = 1;
                x.use_rj = 1;
                x.use_rkd = 1;
                x.rkd_val = source_value(e, e.rk);
            end
            k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu, k_st_w: begin
                x.use_rj = 1;
                x.use_rkd = 1;
                x.rkd_val = source_value(e, e.rd);
            end
            k_b: ;
            k_bl: begin
                x.gr_we = 1;
                x.dest = 5'd1;
            end
            k_lu12i_w, k_pcaddu12i: x.gr_we = 1;
            default: begin
                x.gr_we = 1;
                x.use_rj = 1;
            end
        endcase
        case (e.kind)
            k_sub_w: x.alu = sub;
            k_slt, k_slti: x.alu = slt;
            k_sltu, k_sltui: x.alu = sltu;
            k_and, k_andi: x.alu = and_op;
            k_or, k_ori: x.alu = or_op;
            k_nor: x.alu = nor_op;
            k_xor, k_xori: x.alu = xor_op;
            k_sll_w, k_slli_w: x.alu = sll;
            k_srl_w, k_srli_w: x.alu = srl;
            k_sra_w, k_srai_w: x.alu = sra;
            k_lu12i_w: x.alu = lui;
            default: x.alu = add;
        endcase
        x.src2_imm = !(e.kind inside {k_add_w, k_sub_w, k_slt, k_sltu, k_and, k_or, k_nor,
                                      k_xor, k_sll_w, k_srl_w, k_sra_w, k_beq, k_bne, k_blt,
                                      k_bge, k_bltu, k_bgeu, k_b});
        x.src1_pc = e.kind inside {k_pcaddu12i, k_bl, k_jirl};
        x.mem_we = (e.kind == k_st_w);
        x.from_mem = (e.kind == k_ld_w);
        if (e.kind inside {k_andi, k_ori, k_xori}) x.imm = {20'd0, e.imm[11:0]};
        if (e.kind inside {k_slli_w, k_srli_w, k_srai_w}) x.imm = {27'd0, e.imm[4:0]};
        if (e.kind inside {k_lu12i_w, k_pcaddu12i}) x.imm = {e.imm[19:0], 12'd0};
        if (e.kind inside {k_bl, k_jirl}) x.imm = 32'd4;
        x.rj_val = source_value(e, e.rj);
        x.pc = e.pc;
        case (e.kind)
            k_beq:  x.taken = (x.rj_val == x.rkd_val);
            k_bne:  x.taken = (x.rj_val != x.rkd_val);
            k_blt:  x.taken = ($signed(x.rj_val) < $signed(x.rkd_val));
            k_bge:  x.taken = ($signed(x.rj_val) >= $signed(x.rkd_val));
            k_bltu: x.taken = (x.rj_val < x.rkd_val);
            k_bgeu: x.taken = (x.rj_val >= x.rkd_val);
            k_b, k_bl, k_jirl: x.taken = 1;
            default: x.taken = 0;
        endcase
        x.target = (e.kind == k_jirl) ? x.rj_val + off16 :
                   (e.kind inside {k_b, k_bl}) ? e.pc + off26 : e.pc + off16;
        return x;
    endfunction

    task automatic compare_outputs(input exp_t x, input bit leaving);
        check(out_alu_op == x.alu, "out_alu_op");
        check(out_gr_we == x.gr_we, "out_gr_we");
        check(out_mem_we == x.mem_we, "out_mem_we");
        check(out_res_from_mem == x.from_mem, "out_res_from_mem");
        check(out_src1_is_pc == x.src1_pc, "out_src1_is_pc");
        check(out_src2_is_imm == x.src2_imm, "out_src2_is_imm");
        check(out_pc == x.pc, "out_pc");
        if (x.gr_we) check(out_dest == x.dest, "out_dest");
        if (x.src2_imm) check(out_imm == x.imm, "out_imm");
        if (x.use_rj) check(out_rj_value == x.rj_val, "out_rj_value");
        if (x.use_rkd) check(out_rkd_value == x.rkd_val, "out_rkd_value");
        check(br_taken == (leaving && x.taken), "br_taken");
        if (leaving && x.taken) check(br_target == x.target, "br_target");
    endtask

    task automatic add_entry(input kind_e k, input logic [4:0] rd, rj, rk,
                             input logic [31:0] imm, pc,
                             input logic [4:0] esd, input logic [31:0] esr, input int stall,
                             input logic [4:0] msd, input logic [31:0] msr,
                             input logic [4:0] wsd, input logic [31:0] wsr);
        table_q.push_back('{k, rd, rj, rk, imm, pc, esd, msd, wsd, esr, msr, wsr, stall,
                            int'($urandom % 3)});
    endtask

    task automatic run_entry(input entry_t e);
        exp_t x;
        x = model(e);
        @(posedge clk);
        in_valid <= 1'b1;
        in_inst <= encode(e);
        in_pc <= e.pc;
        es_dest <= e.es_dest;
        es_result <= e.es_res;
        es_load <= (e.stall > 0);
        ms_dest <= e.ms_dest;
        ms_result <= e.ms_res;
        ws_dest <= e.ws_dest;
        ws_result <= e.ws_res;
        out_ready <= (e.gap == 0);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
        for (int i = 0; i < e.stall; i++) begin
            @(negedge clk);
            check(!out_valid && !in_ready, "load-use stall");
            @(posedge clk);
            if (i == e.stall - 1) es_load <= 1'b0;
        end
        for (int i = 0; i < e.gap; i++) begin
            @(negedge clk);
            check(out_valid && !in_ready, "back-pressure hold");
            compare_outputs(x, 1'b0);
            @(posedge clk);
            if (i == e.gap - 1) out_ready <= 1'b1;
        end
        @(negedge clk);
        while (!(out_valid && out_ready)) @(negedge clk);
        compare_outputs(x, 1'b1);
        @(negedge clk);
        check(!out_valid && !br_taken, "single issue");
    endtask

    initial begin
        void'($urandom(55987));
        reset = 1'b1;
        in_valid = 0;
        in_inst = '0;
        in_pc = '0;
        out_ready = 0;
        wb_we = 0;
        wb_addr = '0;
        wb_data = '0;
        {es_dest, ms_dest, ws_dest, es_load} = '0;
        {es_result, ms_result, ws_result} = '0;
        shadow[0] = '0;
        for (int r = 1; r < 32; r++) shadow[r] = $urandom;
        shadow[20] = 32'hffff_fff0;
        shadow[21] = 32'h0000_0010;

        // register forms, then immediate forms
        add_entry(k_add_w, 3, 1, 2, 0, 32'h1000, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_sub_w, 4, 5, 6, 0, 32'h1004, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_slt, 4, 20, 21, 0, 32'h1008, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_sltu, 4, 20, 21, 0, 32'h100c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_and, 7, 8, 9, 0, 32'h1010, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_or, 7, 10, 11, 0, 32'h1014, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_nor, 7, 12, 13, 0, 32'h1018, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_xor, 7, 14, 15, 0, 32'h101c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_sll_w, 7, 16, 17, 0, 32'h1020, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_srl_w, 7, 18, 19, 0, 32'h1024, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_sra_w, 7, 22, 23, 0, 32'h1028, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_addi_w, 3, 1, 0, 32'hffb, 32'h102c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_slti, 3, 2, 0, 32'h801, 32'h1030, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_sltui, 3, 2, 0, 32'h7ff, 32'h1034, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_andi, 3, 4, 0, 32'hf0f, 32'h1038, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_ori, 3, 5, 0, 32'h8a5, 32'h103c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_xori, 3, 6, 0, 32'hfff, 32'h1040, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_slli_w, 3, 7, 0, 32'd7, 32'h1044, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_srli_w, 3, 8, 0, 32'd31, 32'h1048, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_srai_w, 3, 9, 0, 32'd1, 32'h104c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_lu12i_w, 3, 0, 0, 32'h80001, 32'h1050, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_pcaddu12i, 3, 0, 0, 32'h00123, 32'h1054, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_ld_w, 3, 7, 0, 32'hff0, 32'h1058, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_st_w, 6, 7, 0, 32'h010, 32'h105c, 0, 0, 0, 0, 0, 0, 0);
        // bypass priority and r0
        add_entry(k_add_w, 5, 8, 9, 0, 32'h2000, 8, 111, 0, 8, 222, 9, 333);
        add_entry(k_add_w, 5, 8, 9, 0, 32'h2004, 0, 111, 0, 9, 222, 9, 333);
        add_entry(k_add_w, 5, 0, 0, 0, 32'h2008, 0, 111, 0, 0, 222, 0, 333);
        // load-use
        add_entry(k_add_w, 5, 10, 11, 0, 32'h3000, 11, 32'h1234, 3, 0, 0, 0, 0);
        add_entry(k_beq, 12, 13, 0, 32'h0010, 32'h3004, 13, 77, 2, 12, 77, 0, 0);
        // branches
        add_entry(k_bne, 13, 12, 0, 32'h0010, 32'h4000, 12, 77, 0, 13, 77, 0, 0);
        add_entry(k_blt, 21, 20, 0, 32'hfff0, 32'h4004, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_bge, 21, 20, 0, 32'h0020, 32'h4008, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_bltu, 21, 20, 0, 32'h0020, 32'h400c, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_bgeu, 21, 20, 0, 32'h0020, 32'h4010, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_b, 0, 0, 0, 32'h3ff_fff8, 32'h4014, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_bl, 0, 0, 0, 32'h000_0100, 32'h4018, 0, 0, 0, 0, 0, 0, 0);
        add_entry(k_jirl, 3, 14, 0, 32'h0004, 32'h401c, 14, 32'h8000, 0, 0, 0, 0, 0);
        limit = 40 * table_q.size() + 100;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            wb_we <= 1'b1;
            wb_addr <= 5'(r);
            wb_data <= shadow[r];
        end
        @(posedge clk);
        wb_we <= 1'b0;

        foreach (table_q[i]) run_entry(table_q[i]);

        $display("errors: %0d in %0d entries", errors, table_q.size());
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // from fetch
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`ID_INST_W-1:0]  in_inst,
    input  logic [`ID_XLEN-1:0]    in_pc,
    // to execute
    output logic                   out_valid,
    input  logic                   out_ready,
    output alu_op_e                out_alu_op,
    output logic                   out_src1_is_pc,
    output logic                   out_src2_is_imm,
    output logic                   out_gr_we,
    output logic                   out_mem_we,
    output logic                   out_res_from_mem,
    output logic [`ID_REG_AW-1:0]  out_dest,
    output logic [`ID_XLEN-1:0]    out_imm,
    output logic [`ID_XLEN-1:0]    out_rj_value,
    output logic [`ID_XLEN-1:0]    out_rkd_value,
    output logic [`ID_XLEN-1:0]    out_pc,
    // redirect to fetch
    output logic                   br_taken,
    output logic [`ID_XLEN-1:0]    br_target,
    // regfile write from writeback
    input  logic                   wb_we,
    input  logic [`ID_REG_AW-1:0]  wb_addr,
    input  logic [`ID_XLEN-1:0]    wb_data,
    // bypass from later stages
    input  logic [`ID_REG_AW-1:0]  es_dest,
    input  logic [`ID_XLEN-1:0]    es_result,
    input  logic                   es_load,
    input  logic [`ID_REG_AW-1:0]  ms_dest,
    input  logic [`ID_XLEN-1:0]    ms_result,
    input  logic [`ID_REG_AW-1:0]  ws_dest,
    input  logic [`ID_XLEN-1:0]    ws_result
);

    logic                  held_valid;
    logic [`ID_INST_W-1:0] inst_r;
    logic [`ID_XLEN-1:0]   pc_r;
    logic                  leave;
    logic                  load_stall;
    decoded_t              dec;

    fwd_if fwd ();

    assign fwd.es_dest   = es_dest;
    assign fwd.es_result = es_result;
    assign fwd.es_load   = es_load;
    assign fwd.ms_dest   = ms_dest;
    assign fwd.ms_result = ms_result;
    assign fwd.ws_dest   = ws_dest;
    assign fwd.ws_result = ws_result;

    // single slot, refills in the cycle it drains
    assign in_ready = ~held_valid | leave;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            inst_r <= in_inst;
            pc_r   <= in_pc;
        end
    end

    inst_decoder u_decoder (
        .inst (inst_r),
        .dec  (dec)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .dec        (dec),
        .fwd        (fwd.dst),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .rj_value   (out_rj_value),
        .rkd_value  (out_rkd_value),
        .load_stall (load_stall)
    );

    branch_issue u_branch_issue (
        .dec        (dec),
        .pc         (pc_r),
        .rj_value   (out_rj_value),
        .rkd_value  (out_rkd_value),
        .load_stall (load_stall),
        .held_valid (held_valid),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .leave      (leave),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    assign out_alu_op       = dec.alu_op;
    assign out_src1_is_pc   = dec.src1_is_pc;
    assign out_src2_is_imm  = dec.src2_is_imm;
    assign out_gr_we        = dec.gr_we;
    assign out_mem_we       = dec.mem_we;
    assign out_res_from_mem = dec.res_from_mem;
    assign out_dest         = dec.dest;
    assign out_imm          = dec.imm;
    assign out_pc           = pc_r;

endmodule

`default_nettype wire

//--- branch_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module branch_issue
    import id_pkg::*;
(
    input  decoded_t            dec,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic [`ID_XLEN-1:0] rj_value,
    input  logic [`ID_XLEN-1:0] rkd_value,
    input  logic                load_stall,
    input  logic                held_valid,
    input  logic                out_ready,
    output logic                out_valid,
    output logic                leave,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target
);

    logic [`ID_XLEN:0] diff;
    logic              rj_eq;
    logic              rj_lt;
    logic              rj_ltu;
    logic              taken;

    // one subtract, borrow gives the unsigned compare
    assign diff   = {1'b0, rj_value} - {1'b0, rkd_value};
    assign rj_ltu = diff[`ID_XLEN];
    assign rj_eq  = (rj_value == rkd_value);
    assign rj_lt  = (rj_value[`ID_XLEN-1] & ~rkd_value[`ID_XLEN-1])
                    | (~(rj_value[`ID_XLEN-1] ^ rkd_value[`ID_XLEN-1]) & diff[`ID_XLEN-1]);

    always_comb begin
        case (dec.br_kind)
            beq:     taken = rj_eq;
            bne:     taken = ~rj_eq;
            blt:     taken = rj_lt;
            bge:     taken = ~rj_lt;
            bltu:    taken = rj_ltu;
            bgeu:    taken = ~rj_ltu;
            jump_b,
            jump_bl,
            jirl:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl offset is already si16 << 2 in br_offs
    assign br_target = ((dec.br_kind == jirl) ? rj_value : pc) + dec.br_offs;

    assign out_valid = held_valid & ~load_stall;
    assign leave     = out_valid & out_ready;
    assign br_taken  = taken & leave;

endmodule

`default_nettype wire

//--- operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module operand_fetch
    import id_pkg::*;
(
    input  logic                  clk,
    input  decoded_t              dec,
    fwd_if.dst                    fwd,
    input  logic                  wb_we,
    input  logic [`ID_REG_AW-1:0] wb_addr,
    input  logic [`ID_XLEN-1:0]   wb_data,
    output logic [`ID_XLEN-1:0]   rj_value,
    output logic [`ID_XLEN-1:0]   rkd_value,
    output logic                  load_stall
);

    logic [`ID_XLEN-1:0] rf_rj;
    logic [`ID_XLEN-1:0] rf_rkd;

    function automatic logic hit(
        input logic                  use_src,
        input logic [`ID_REG_AW-1:0] src,
        input logic [`ID_REG_AW-1:0] stage_dest
    );
        return use_src && (src != '0) && (src == stage_dest);
    endfunction

    // youngest producer wins
    function automatic logic [`ID_XLEN-1:0] pick(
        input logic                  use_src,
        input logic [`ID_REG_AW-1:0] src,
        input logic [`ID_XLEN-1:0]   rf_val
    );
        if (hit(use_src, src, fwd.es_dest)) begin
            return fwd.es_result;
        end else if (hit(use_src, src, fwd.ms_dest)) begin
            return fwd.ms_result;
        end else if (hit(use_src, src, fwd.ws_dest)) begin
            return fwd.ws_result;
        end
        return rf_val;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rkd_addr),
        .rdata1 (rf_rj),
        .rdata2 (rf_rkd),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    always_comb begin
        rj_value   = pick(dec.use_rj, dec.rj, rf_rj);
        rkd_value  = pick(dec.use_rkd, dec.rkd_addr, rf_rkd);
        // load data is not ready until mem stage
        load_stall = fwd.es_load
                     && (hit(dec.use_rj, dec.rj, fwd.es_dest)
                         || hit(dec.use_rkd, dec.rkd_addr, fwd.es_dest));
    end

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module inst_decoder
    import id_pkg::*;
(
    input  logic [`ID_INST_W-1:0] inst,
    output decoded_t              dec
);

    logic [5:0]            op6;
    logic [3:0]            op4;
    logic [1:0]            op2;
    logic [4:0]            op5;
    logic [`ID_REG_AW-1:0] rd;
    logic [`ID_REG_AW-1:0] rj;
    logic [`ID_REG_AW-1:0] rk;
    logic [11:0]           i12;
    logic [15:0]           i16;
    logic [19:0]           i20;
    logic [25:0]           i26;
    logic                  known;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    // offs26 is split, high part sits in the low bits
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        dec          = '0;
        dec.alu_op   = add;
        dec.br_kind  = none;
        dec.dest     = rd;
        dec.rj       = rj;
        dec.rkd_addr = rk;
        dec.imm      = {{20{i12[11]}}, i12};
        dec.br_offs  = {{14{i16[15]}}, i16, 2'b00};
        known        = 1'b1;
        case (op6)
            6'h00: begin
                dec.gr_we  = 1'b1;
                dec.use_rj = 1'b1;
                if (op4 == 4'h0 && op2 == 2'h1) begin
                    // three-register alu group
                    dec.use_rkd = 1'b1;
                    case (op5)
                        5'h00:   dec.alu_op = add;
                        5'h02:   dec.alu_op = sub;
                        5'h04:   dec.alu_op = slt;
                        5'h05:   dec.alu_op = sltu;
                        5'h08:   dec.alu_op = nor_op;
                        5'h09:   dec.alu_op = and_op;
                        5'h0a:   dec.alu_op = or_op;
                        5'h0b:   dec.alu_op = xor_op;
                        5'h0e:   dec.alu_op = sll;
                        5'h0f:   dec.alu_op = srl;
                        5'h10:   dec.alu_op = sra;
                        default: known = 1'b0;
                    endcase
                end else if (op4 == 4'h1 && op2 == 2'h0) begin
                    // shift by ui5
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = {27'b0, i12[4:0]};
                    case (op5)
                        5'h01:   dec.alu_op = sll;
                        5'h09:   dec.alu_op = srl;
                        5'h11:   dec.alu_op = sra;
                        default: known = 1'b0;
                    endcase
                end else begin
                    dec.src2_is_imm = 1'b1;
                    // logic immediates are zero-extended
                    if (op4 >= 4'hd) begin
                        dec.imm = {20'b0, i12};
                    end
                    case (op4)
                        4'h8:    dec.alu_op = slt;
                        4'h9:    dec.alu_op = sltu;
                        4'ha:    dec.alu_op = add;
                        4'hd:    dec.alu_op = and_op;
                        4'he:    dec.alu_op = or_op;
                        4'hf:    dec.alu_op = xor_op;
                        default: known = 1'b0;
                    endcase
                end
            end
            6'h05, 6'h07: begin
                // lu12i.w and pcaddu12i
                known           = ~inst[25];
                dec.gr_we       = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = {i20, 12'b0};
                if (op6 == 6'h07) begin
                    dec.src1_is_pc = 1'b1;
                end else begin
                    dec.alu_op = lui;
                end
            end
            6'h0a: begin
                dec.use_rj      = 1'b1;
                dec.src2_is_imm = 1'b1;
                if (op4 == 4'h2) begin
                    dec.gr_we        = 1'b1;
                    dec.res_from_mem = 1'b1;
                end else if (op4 == 4'h6) begin
                    // store data comes from rd
                    dec.mem_we   = 1'b1;
                    dec.use_rkd  = 1'b1;
                    dec.rkd_addr = rd;
                end else begin
                    known = 1'b0;
                end
            end
            6'h13: begin
                dec.br_kind     = jirl;
                dec.gr_we       = 1'b1;
                dec.use_rj      = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = 32'd4;
            end
            6'h14: begin
                dec.br_kind = jump_b;
                dec.br_offs = {{4{i26[25]}}, i26, 2'b00};
            end
            6'h15: begin
                // link value pc+4 into r1
                dec.br_kind     = jump_bl;
                dec.gr_we       = 1'b1;
                dec.dest        = 5'd1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = 32'd4;
                dec.br_offs     = {{4{i26[25]}}, i26, 2'b00};
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                dec.use_rj   = 1'b1;
                dec.use_rkd  = 1'b1;
                dec.rkd_addr = rd;
                case (op6[2:0])
                    3'h6:    dec.br_kind = beq;
                    3'h7:    dec.br_kind = bne;
                    3'h0:    dec.br_kind = blt;
                    3'h1:    dec.br_kind = bge;
                    3'h2:    dec.br_kind = bltu;
                    default: dec.br_kind = bgeu;
                endcase
            end
            default: known = 1'b0;
        endcase
        // unsupported word becomes a bubble
        if (!known) begin
            dec         = '0;
            dec.alu_op  = add;
            dec.br_kind = none;
        end
    end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module regfile (
    input  logic                  clk,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_XLEN-1:0]   rdata1,
    output logic [`ID_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`ID_REG_AW-1:0] waddr,
    input  logic [`ID_XLEN-1:0]   wdata
);

    logic [`ID_XLEN-1:0] rf [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

//--- fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

interface fwd_if;
    // destination zero means no register write in that stage
    logic [`ID_REG_AW-1:0] es_dest;
    logic [`ID_XLEN-1:0]   es_result;
    logic                  es_load;
    logic [`ID_REG_AW-1:0] ms_dest;
    logic [`ID_XLEN-1:0]   ms_result;
    logic [`ID_REG_AW-1:0] ws_dest;
    logic [`ID_XLEN-1:0]   ws_result;

    modport src (
        output es_dest, es_result, es_load,
        output ms_dest, ms_result,
        output ws_dest, ws_result
    );

    modport dst (
        input es_dest, es_result, es_load,
        input ms_dest, ms_result,
        input ws_dest, ws_result
    );
endinterface

`default_nettype wire

//--- id_pkg.sv
`default_nettype none

`include "id_cfg.svh"

package id_pkg;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        nor_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        lui
    } alu_op_e;

    // branch and jump kinds
    typedef enum logic [3:0] {
        none,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu,
        jump_b,
        jump_bl,
        jirl
    } br_kind_e;

    typedef struct packed {
        alu_op_e               alu_op;
        br_kind_e              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  gr_we;
        logic                  mem_we;
        logic                  res_from_mem;
        logic [`ID_REG_AW-1:0] dest;
        logic [`ID_REG_AW-1:0] rj;
        logic [`ID_REG_AW-1:0] rkd_addr;
        logic                  use_rj;
        logic                  use_rkd;
        logic [`ID_XLEN-1:0]   imm;
        logic [`ID_XLEN-1:0]   br_offs;
    } decoded_t;

endpackage

`default_nettype wire

//--- id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// data and address width
`define ID_XLEN 32

// instruction word width
`define ID_INST_W 32

// register address width
`define ID_REG_AW 5

// architectural integer registers, r0 included
`define ID_NUM_REGS 32

`endif
